// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_cache
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides pass or fail, a missing pass line fails the target
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bank_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_config.svh"

module bank_arbiter
    import cache_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`CACHE_NUM_BANKS-1:0] bank_mem_valid,
    input  mem_req_t                    bank_mem_req [`CACHE_NUM_BANKS],
    output logic [`CACHE_NUM_BANKS-1:0] bank_mem_grant,
    output logic [`CACHE_NUM_BANKS-1:0] bank_mem_done,
    output mem_rsp_t                    mem_rsp_out,
    output logic                        mem_req_valid,
    output mem_req_t                    mem_req,
    input  logic                        mem_req_ready,
    input  logic                        mem_rsp_valid,
    input  mem_rsp_t                    mem_rsp,
    input  logic [`CACHE_NUM_BANKS-1:0] bank_rsp_valid,
    input  cpu_rsp_t                    bank_rsp [`CACHE_NUM_BANKS],
    output logic [`CACHE_NUM_BANKS-1:0] bank_rsp_grant,
    output logic                        cpu_rsp_valid,
    output cpu_rsp_t                    cpu_rsp,
    input  logic                        cpu_rsp_ready
);

    localparam int NB = `CACHE_NUM_BANKS;

    logic              mem_busy;   // a transaction is in flight, issue or wait
    logic              mem_issue;  // still presenting it to memory
    logic [BANK_W-1:0] mem_ptr;    // last winner, also the owner of the open transaction
    logic [BANK_W-1:0] mem_pick;
    mem_req_t          mem_req_q;

    logic              rsp_busy;
    logic [BANK_W-1:0] rsp_ptr;  // last winner, its rsp is what the cpu sees
    logic [BANK_W-1:0] rsp_pick;

    // first requester after last, wraps round
    function automatic logic [BANK_W-1:0] rr_pick(input logic [NB-1:0] req,
                                                  input logic [BANK_W-1:0] last);
        logic [BANK_W-1:0] idx;
        rr_pick = last;
        for (int k = NB; k >= 1; k--) begin
            idx = last + k[BANK_W-1:0];
            if (req[idx])
                rr_pick = idx;  // smaller k wins, so the bank right after last
        end
    endfunction

    assign mem_pick = rr_pick(bank_mem_valid, mem_ptr);
    assign rsp_pick = rr_pick(bank_rsp_valid, rsp_ptr);

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_busy       <= 1'b0;
            mem_issue      <= 1'b0;
            mem_ptr        <= '0;
            bank_mem_grant <= '0;
        end else begin
            bank_mem_grant <= '0;  // grant is a one-cycle pulse
            if (!mem_busy && (bank_mem_valid != '0)) begin
                mem_busy                 <= 1'b1;
                mem_issue                <= 1'b1;
                mem_ptr                  <= mem_pick;
                bank_mem_grant[mem_pick] <= 1'b1;
            end else begin
                if (mem_issue && mem_req_ready)
                    mem_issue <= 1'b0;
                if (mem_rsp_valid)
                    mem_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy)
            mem_req_q <= bank_mem_req[mem_pick];  // captured with the grant
    end

    assign mem_req_valid = mem_issue;
    assign mem_req       = mem_req_q;
    assign mem_rsp_out   = mem_rsp;  // broadcast, done picks the owner

    always_comb begin
        bank_mem_done          = '0;
        bank_mem_done[mem_ptr] = mem_rsp_valid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_busy <= 1'b0;
            rsp_ptr  <= '0;
        end else if (!rsp_busy && (bank_rsp_valid != '0)) begin
            rsp_busy <= 1'b1;
            rsp_ptr  <= rsp_pick;
        end else if (rsp_busy && cpu_rsp_ready) begin
            rsp_busy <= 1'b0;
        end
    end

    // granted bank holds its registered rsp, so this path stays a mux
    assign cpu_rsp_valid = rsp_busy;
    assign cpu_rsp       = bank_rsp[rsp_ptr];

    always_comb begin
        bank_rsp_grant          = '0;
        bank_rsp_grant[rsp_ptr] = rsp_busy && cpu_rsp_ready;
    end

    // one outstanding only, memory answers after the request was taken
    a_rsp_when_busy: assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid |-> (mem_busy && !mem_issue));

endmodule

`default_nettype wire

// ==== bank_router.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_config.svh"

module bank_router
    import cache_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cpu_req_valid,
    input  cpu_req_t                    cpu_req,
    output logic                        cpu_req_ready,
    output logic [`CACHE_NUM_BANKS-1:0] bank_req_valid,
    output cpu_req_t                    bank_req [`CACHE_NUM_BANKS],
    input  logic [`CACHE_NUM_BANKS-1:0] bank_credit_return
);

    localparam int NB    = `CACHE_NUM_BANKS;
    localparam int CNT_W = $clog2(`CACHE_BANK_CREDITS + 1);
    localparam logic [CNT_W-1:0] MAX_CREDITS = CNT_W'(`CACHE_BANK_CREDITS);

    logic [CNT_W-1:0]  credits [NB];  // free slots in each bank queue
    logic              loaded;        // low for the first cycle out of reset
    logic [BANK_W-1:0] sel;
    logic              fire;
    logic [NB-1:0]     spend;         // one-hot, bank taking a request this cycle

    assign sel = cpu_req.addr[BANK_LSB +: BANK_W];

    // ready only looks at the target bank, other banks may be full
    assign cpu_req_ready = loaded && (credits[sel] != '0);
    assign fire          = cpu_req_valid && cpu_req_ready;

    always_comb begin
        spend      = '0;
        spend[sel] = fire;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            loaded         <= 1'b0;
            bank_req_valid <= '0;
            for (int b = 0; b < NB; b++) begin
                credits[b] <= MAX_CREDITS;
            end
        end else begin
            loaded         <= 1'b1;
            bank_req_valid <= spend;  // lands in the bank queue next edge
            for (int b = 0; b < NB; b++) begin
                // spend and return together leave the count alone
                if (spend[b] && !bank_credit_return[b]) begin
                    if (credits[b] != '0)
                        credits[b] <= credits[b] - 1'b1;
                end else if (!spend[b] && bank_credit_return[b]) begin
                    if (credits[b] != MAX_CREDITS)
                        credits[b] <= credits[b] + 1'b1;
                end
            end
        end
    end

    // payload regs, only the selected bank copy is refreshed
    always_ff @(posedge clk) begin
        for (int b = 0; b < NB; b++) begin
            if (spend[b])
                bank_req[b] <= cpu_req;
        end
    end

    for (genvar b = 0; b < NB; b++) begin : g_credit_chk
        // counter never has to saturate, the bank must never return more than it got
        a_credit_range: assert property (@(posedge clk) disable iff (rst)
            !(spend[b] && !bank_credit_return[b] && credits[b] == '0) &&
            !(bank_credit_return[b] && !spend[b] && credits[b] == MAX_CREDITS));
    end

endmodule

`default_nettype wire

// ==== cache_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_config.svh"

module cache_bank
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req_valid,
    input  cpu_req_t req,
    output logic     credit_return,
    output logic     mem_valid,
    output mem_req_t mem_req,
    input  logic     mem_grant,
    input  logic     mem_done,
    input  mem_rsp_t mem_rsp,
    output logic     rsp_valid,
    output cpu_rsp_t rsp,
    input  logic     rsp_grant
);

    localparam int LINES = `CACHE_BANK_LINES;
    localparam int WORDS = `CACHE_LINE_WORDS;
    localparam int DEPTH = `CACHE_BANK_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    cpu_req_t         queue [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    logic [TAG_W-1:0]         tag_mem    [LINES];
    logic [WORDS-1:0]         word_valid [LINES];  // per word, so a partial line never serves stale data
    logic [`CACHE_DATA_W-1:0] data_mem   [LINES*WORDS];

    bank_state_e               state;
    cpu_req_t                  cur;  // entry being served
    logic [TAG_W-1:0]          cur_tag;
    logic [INDEX_W-1:0]        cur_index;
    logic [WORD_W-1:0]         cur_word;
    logic [INDEX_W+WORD_W-1:0] cur_slot;
    logic                      hit;
    logic                      tag_change;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign cur_tag   = cur.addr[TAG_LSB +: TAG_W];
    assign cur_index = cur.addr[INDEX_LSB +: INDEX_W];
    assign cur_word  = cur.addr[WORD_LSB +: WORD_W];
    assign cur_slot  = {cur_index, cur_word};

    // combinational tag match, arrays only change at the end of a miss
    assign tag_change = tag_mem[cur_index] != cur_tag;
    assign hit        = !tag_change && word_valid[cur_index][cur_word];

    assign pop           = (state == ST_IDLE) && (count != '0);
    assign credit_return = pop;  // slot is free once popped

    assign mem_valid     = (state == ST_MEM_REQ);
    assign mem_req.we    = (cur.op == OP_WRITE);
    assign mem_req.addr  = cur.addr;
    assign mem_req.wdata = cur.wdata;
    assign rsp_valid     = (state == ST_RESPOND);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (req_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            if (req_valid && !pop)
                count <= count + 1'b1;
            else if (!req_valid && pop)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid)
            queue[wr_ptr] <= req;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:     if (pop) state <= ST_LOOKUP;
                ST_LOOKUP:   state <= (cur.op == OP_READ && hit) ? ST_RESPOND : ST_MEM_REQ;
                ST_MEM_REQ:  if (mem_grant) state <= ST_MEM_WAIT;
                ST_MEM_WAIT: if (mem_done) state <= ST_RESPOND;
                ST_RESPOND:  if (rsp_grant) state <= ST_IDLE;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    // read miss fill, a new tag drops the other words of the line
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LINES; i++) begin
                word_valid[i] <= '0;
            end
        end else if (state == ST_MEM_WAIT && mem_done && cur.op == OP_READ) begin
            if (tag_change)
                word_valid[cur_index] <= WORDS'(1) << cur_word;
            else
                word_valid[cur_index][cur_word] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            cur <= queue[rd_ptr];
        if (state == ST_LOOKUP && cur.op == OP_READ && hit) begin
            rsp.id    <= cur.id;
            rsp.op    <= cur.op;
            rsp.rdata <= data_mem[cur_slot];
            rsp.hit   <= 1'b1;
        end
        if (state == ST_MEM_WAIT && mem_done) begin
            rsp.id    <= cur.id;
            rsp.op    <= cur.op;
            rsp.hit   <= hit;  // always 0 for a read here
            rsp.rdata <= (cur.op == OP_READ) ? mem_rsp.rdata : '0;
            if (cur.op == OP_READ) begin
                data_mem[cur_slot]  <= mem_rsp.rdata;
                tag_mem[cur_index] <= cur_tag;
            end else if (hit) begin
                data_mem[cur_slot] <= cur.wdata;  // write hit keeps array in step, miss does not allocate
            end
        end
    end

    // router credits must keep the queue from ever filling past depth
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> (count < CNT_W'(DEPTH)));

    // arbiter grants only a bank that is still holding its request up
    a_grant_when_valid: assert property (@(posedge clk) disable iff (rst)
        mem_grant |-> mem_valid);

endmodule

`default_nettype wire

// ==== cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// cpu port widths
`define CACHE_ADDR_W 32
`define CACHE_DATA_W 32
`define CACHE_ID_W 4       // request id, echoed back on the response

// bank geometry
`define CACHE_NUM_BANKS 4    // must stay a power of two, bank bits come from the address
`define CACHE_BANK_LINES 64  // direct mapped lines per bank
`define CACHE_LINE_WORDS 4   // 32-bit words per line

// input queue depth per bank, router starts with this many credits
`define CACHE_BANK_CREDITS 2

`endif

// ==== cache_pkg.sv ====
`default_nettype none

`include "cache_config.svh"

package cache_pkg;

    // byte address split, lsb first: byte | word | bank | index | tag
    localparam int BYTE_W  = 2;
    localparam int WORD_W  = $clog2(`CACHE_LINE_WORDS);
    localparam int BANK_W  = $clog2(`CACHE_NUM_BANKS);
    localparam int INDEX_W = $clog2(`CACHE_BANK_LINES);
    localparam int TAG_W   = `CACHE_ADDR_W - INDEX_W - BANK_W - WORD_W - BYTE_W;

    localparam int WORD_LSB  = BYTE_W;
    localparam int BANK_LSB  = WORD_LSB + WORD_W;
    localparam int INDEX_LSB = BANK_LSB + BANK_W;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_W;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cache_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,      // waiting on queue
        ST_LOOKUP,    // tag compare on the popped entry
        ST_MEM_REQ,   // asking the arbiter for memory
        ST_MEM_WAIT,  // granted, waiting for done
        ST_RESPOND    // holding rsp until the cpu takes it
    } bank_state_e;

    typedef struct packed {
        cache_op_e                op;
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
        logic [`CACHE_ID_W-1:0]   id;
    } cpu_req_t;

    typedef struct packed {
        logic [`CACHE_ID_W-1:0]   id;
        cache_op_e                op;
        logic [`CACHE_DATA_W-1:0] rdata;  // zero for writes
        logic                     hit;
    } cpu_rsp_t;

    typedef struct packed {
        logic                     we;
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`CACHE_DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== cache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_config.svh"

module cache_top
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cpu_req_valid,
    output logic     cpu_req_ready,
    input  cpu_req_t cpu_req,
    output logic     cpu_rsp_valid,
    input  logic     cpu_rsp_ready,
    output cpu_rsp_t cpu_rsp,
    output logic     mem_req_valid,
    input  logic     mem_req_ready,
    output mem_req_t mem_req,
    input  logic     mem_rsp_valid,
    input  mem_rsp_t mem_rsp
);

    localparam int NB = `CACHE_NUM_BANKS;

    // router to banks
    logic [NB-1:0] bank_req_valid;
    cpu_req_t      bank_req [NB];
    logic [NB-1:0] bank_credit_return;

    // banks to arbiter
    logic [NB-1:0] bank_mem_valid;
    mem_req_t      bank_mem_req [NB];
    logic [NB-1:0] bank_mem_grant;
    logic [NB-1:0] bank_mem_done;
    mem_rsp_t      mem_rsp_bcast;
    logic [NB-1:0] bank_rsp_valid;
    cpu_rsp_t      bank_rsp [NB];
    logic [NB-1:0] bank_rsp_grant;

    bank_router u_router (
        .clk                (clk),
        .rst                (rst),
        .cpu_req_valid      (cpu_req_valid),
        .cpu_req            (cpu_req),
        .cpu_req_ready      (cpu_req_ready),
        .bank_req_valid     (bank_req_valid),
        .bank_req           (bank_req),
        .bank_credit_return (bank_credit_return)
    );

    for (genvar g = 0; g < NB; g++) begin : g_bank
        cache_bank u_bank (
            .clk           (clk),
            .rst           (rst),
            .req_valid     (bank_req_valid[g]),
            .req           (bank_req[g]),
            .credit_return (bank_credit_return[g]),
            .mem_valid     (bank_mem_valid[g]),
            .mem_req       (bank_mem_req[g]),
            .mem_grant     (bank_mem_grant[g]),
            .mem_done      (bank_mem_done[g]),
            .mem_rsp       (mem_rsp_bcast),
            .rsp_valid     (bank_rsp_valid[g]),
            .rsp           (bank_rsp[g]),
            .rsp_grant     (bank_rsp_grant[g])
        );
    end

    bank_arbiter u_arbiter (
        .clk            (clk),
        .rst            (rst),
        .bank_mem_valid (bank_mem_valid),
        .bank_mem_req   (bank_mem_req),
        .bank_mem_grant (bank_mem_grant),
        .bank_mem_done  (bank_mem_done),
        .mem_rsp_out    (mem_rsp_bcast),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .bank_rsp_valid (bank_rsp_valid),
        .bank_rsp       (bank_rsp),
        .bank_rsp_grant (bank_rsp_grant),
        .cpu_rsp_valid  (cpu_rsp_valid),
        .cpu_rsp        (cpu_rsp),
        .cpu_rsp_ready  (cpu_rsp_ready)
    );

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
cache_pkg.sv
bank_router.sv
cache_bank.sv
bank_arbiter.sv
cache_top.sv
tb_memory.sv
tb_cache.sv

// ==== tb_cache.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_config.svh"

module tb_cache
    import cache_pkg::*;
();

    localparam int NB         = `CACHE_NUM_BANKS;
    localparam int LINES      = `CACHE_BANK_LINES;
    localparam int NUM_IDS    = 1 << `CACHE_ID_W;
    localparam int WAIT_LIMIT = 500;  // cycles

    logic clk;
    logic rst;
    logic cpu_req_valid;
    logic cpu_req_ready;
    cpu_req_t cpu_req;
    logic cpu_rsp_valid;
    logic cpu_rsp_ready;
    cpu_rsp_t cpu_rsp;
    logic mem_req_valid;
    logic mem_req_ready;
    mem_req_t mem_req;
    logic mem_rsp_valid;
    mem_rsp_t mem_rsp;
    logic mem_stall;
    logic [1:0] mem_latency;
    logic hold_rsp;       // force cpu_rsp_ready low
    logic random_stalls;  // random gaps on both ready sides
    logic [31:0] stim_lfsr;
    logic [31:0] env_lfsr;

    // model of the cache, one entry per bank and line
    logic [TAG_W-1:0]             ref_tag   [NB*LINES];
    logic [`CACHE_LINE_WORDS-1:0] ref_valid [NB*LINES];
    logic [31:0]                  ref_mem   [logic [29:0]];

    logic        pending   [NUM_IDS];
    logic [31:0] exp_rdata [NUM_IDS];
    logic        exp_hit   [NUM_IDS];
    cache_op_e   exp_op    [NUM_IDS];
    int          id_bank   [NUM_IDS];
    int          issued_count   [NB];
    int          answered_count [NB];
    logic [`CACHE_ID_W-1:0] next_id;

    cache_top DUT (.*);

    tb_memory u_memory (
        .clk       (clk),
        .rst       (rst),
        .req_valid (mem_req_valid),
        .req_ready (mem_req_ready),
        .req       (mem_req),
        .rsp_valid (mem_rsp_valid),
        .rsp       (mem_rsp),
        .stall     (mem_stall),
        .latency   (mem_latency)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic lfsr_step(inout logic [31:0] s);
        logic out;
        out = s[0];
        s   = s >> 1;
        if (out)
            s = s ^ 32'h8020_0003;  // galois taps 32,22,2,1
        return out;
    endfunction

    function automatic logic [31:0] lfsr_bits(inout logic [31:0] s, input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step(s)};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int index, input int bank,
                                              input int word);
        return (32'(tag) << TAG_LSB) | (32'(index) << INDEX_LSB) |
               (32'(bank) << BANK_LSB) | (32'(word) << WORD_LSB);
    endfunction

    function automatic logic [31:0] fill_word(input logic [29:0] wa);
        return {wa[13:0], wa[29:12]} ^ 32'h6b1d_35a9;
    endfunction

    // expected rdata and hit, updates the model as the bank would
    function automatic void predict(input cache_op_e op, input logic [31:0] addr,
                                    input logic [31:0] wdata, output logic [31:0] rdata,
                                    output logic hit);
        int               line;
        int               word;
        logic [TAG_W-1:0] tag;
        logic [29:0]      wa;
        line = int'(addr[BANK_LSB +: BANK_W]) * LINES + int'(addr[INDEX_LSB +: INDEX_W]);
        word = int'(addr[WORD_LSB +: WORD_W]);
        tag  = addr[TAG_LSB +: TAG_W];
        wa   = addr[31:2];
        hit  = (ref_tag[line] == tag) && ref_valid[line][word];
        if (op == OP_WRITE) begin
            rdata       = '0;
            ref_mem[wa] = wdata;  // write through, no allocate
        end else begin
            rdata = ref_mem.exists(wa) ? ref_mem[wa] : fill_word(wa);
            if (!hit) begin
                if (ref_tag[line] != tag)
                    ref_valid[line] = '0;
                ref_tag[line]         = tag;
                ref_valid[line][word] = 1'b1;
            end
        end
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            report_failure($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // offer one request for up to max_wait edges, record it if taken
    task automatic try_issue(input cache_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata, input int max_wait,
                             output logic accepted);
        int                     waited;
        logic [31:0]            rd;
        logic                   ht;
        logic [`CACHE_ID_W-1:0] id;
        waited = 0;
        @(negedge clk);
        while (pending[next_id]) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                report_failure("timeout waiting for a free request id");
        end
        id            = next_id;
        cpu_req_valid = 1'b1;
        cpu_req.op    = op;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cpu_req.id    = id;
        accepted      = 1'b0;
        waited        = 0;
        while (!accepted && waited < max_wait) begin
            @(posedge clk);
            if (cpu_req_ready)
                accepted = 1'b1;
            else
                waited++;
        end
        if (accepted) begin
            predict(op, addr, wdata, rd, ht);
            exp_rdata[id] = rd;
            exp_hit[id]   = ht;
            exp_op[id]    = op;
            id_bank[id]   = int'(addr[BANK_LSB +: BANK_W]);
            pending[id]   = 1'b1;
            issued_count[id_bank[id]]++;
            next_id++;
        end
        @(negedge clk);
        cpu_req_valid = 1'b0;
    endtask

    task automatic issue(input cache_op_e op, input logic [31:0] addr, input logic [31:0] wdata);
        logic acc;
        try_issue(op, addr, wdata, WAIT_LIMIT, acc);
        if (!acc)
            report_failure("request was not accepted by the cache within the timeout");
    endtask

    task automatic wait_drained();
        int waited;
        int open;
        waited = 0;
        open   = 1;
        while (open != 0) begin
            @(negedge clk);
            open = 0;
            for (int b = 0; b < NB; b++) begin
                open += issued_count[b] - answered_count[b];
            end
            waited++;
            if (waited > 4 * WAIT_LIMIT)
                report_failure("timeout waiting for outstanding responses");
        end
    endtask

    // compare at every response handshake
    always @(posedge clk) begin
        if (!rst && cpu_rsp_valid && cpu_rsp_ready) begin
            if (!pending[cpu_rsp.id])
                report_failure($sformatf("response with id %0d has no outstanding request",
                                         cpu_rsp.id));
            check_value("cpu_rsp.op", 32'(cpu_rsp.op), 32'(exp_op[cpu_rsp.id]));
            check_value("cpu_rsp.rdata", cpu_rsp.rdata, exp_rdata[cpu_rsp.id]);
            check_value("cpu_rsp.hit", 32'(cpu_rsp.hit), 32'(exp_hit[cpu_rsp.id]));
            pending[cpu_rsp.id]                <= 1'b0;
            answered_count[id_bank[cpu_rsp.id]] <= answered_count[id_bank[cpu_rsp.id]] + 1;
        end
    end

    // ready stalls and memory latency
    always @(negedge clk) begin
        mem_stall     = random_stalls && (lfsr_bits(env_lfsr, 2) == 0);
        mem_latency   = 2'(lfsr_bits(env_lfsr, 2));
        cpu_rsp_ready = !hold_rsp && !(random_stalls && (lfsr_bits(env_lfsr, 2) == 0));
    end

    initial begin
        logic        acc;
        int          taken;
        cache_op_e   op;
        logic [31:0] a;
        rst           = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        cpu_rsp_ready = 1'b0;
        mem_stall     = 1'b0;
        mem_latency   = '0;
        hold_rsp      = 1'b0;
        random_stalls = 1'b0;
        stim_lfsr     = 32'he78;
        env_lfsr      = 32'he78;
        next_id       = '0;
        for (int i = 0; i < NUM_IDS; i++) begin
            pending[i] = 1'b0;
        end
        for (int i = 0; i < NB * LINES; i++) begin
            ref_tag[i]   = '0;
            ref_valid[i] = '0;
        end
        for (int b = 0; b < NB; b++) begin
            issued_count[b]   = 0;
            answered_count[b] = 0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // quiet out of reset, ready waits one more edge for the credits
        check_value("cpu_req_ready", 32'(cpu_req_ready), 32'h0);
        check_value("cpu_rsp_valid", 32'(cpu_rsp_valid), 32'h0);
        check_value("mem_req_valid", 32'(mem_req_valid), 32'h0);

        // cold miss then hit
        a = make_addr(5, 3, 1, 2);
        issue(OP_READ, a, '0);
        issue(OP_READ, a, '0);
        wait_drained();

        // write then read back, write to another tag does not allocate
        issue(OP_WRITE, a, 32'hcafe_f00d);
        issue(OP_READ, a, '0);
        issue(OP_WRITE, make_addr(9, 3, 1, 0), 32'h1234_5678);
        issue(OP_READ, make_addr(9, 3, 1, 0), '0);
        wait_drained();

        // two tags fighting over one line, the third word gets dropped
        issue(OP_READ, make_addr(1, 7, 2, 3), '0);
        for (int k = 0; k < 5; k++) begin
            issue(OP_READ, make_addr((k % 2 == 0) ? 1 : 2, 7, 2, 0), '0);
        end
        issue(OP_READ, make_addr(1, 7, 2, 3), '0);
        wait_drained();

        // stalled response side, bank 3 fills its queue and then blocks
        hold_rsp = 1'b1;
        taken    = 0;
        acc      = 1'b1;
        for (int k = 0; k < 6 && acc; k++) begin
            try_issue(OP_READ, make_addr(k + 20, k, 3, 0), '0, 40, acc);
            if (acc)
                taken++;
        end
        // queue depth plus the one held in respond
        check_value("accepted while stalled", 32'(taken), 32'(`CACHE_BANK_CREDITS + 1));
        hold_rsp = 1'b0;
        wait_drained();

        // random mix over a small address pool
        random_stalls = 1'b1;
        for (int n = 0; n < 400; n++) begin
            op = lfsr_bits(stim_lfsr, 1) ? OP_WRITE : OP_READ;
            a  = make_addr(int'(lfsr_bits(stim_lfsr, 2)), int'(lfsr_bits(stim_lfsr, 2)),
                           int'(lfsr_bits(stim_lfsr, 2)), int'(lfsr_bits(stim_lfsr, 2)));
            issue(op, a, lfsr_bits(stim_lfsr, 32));
        end
        wait_drained();
        random_stalls = 1'b0;

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cache_config.svh"

module tb_memory
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    output logic       req_ready,
    input  mem_req_t   req,
    output logic       rsp_valid,
    output mem_rsp_t   rsp,
    input  logic       stall,    // refuse new requests this cycle
    input  logic [1:0] latency   // extra wait, drawn by the testbench
);

    logic [`CACHE_DATA_W-1:0] shadow [logic [29:0]];  // word addressed, only written words live here
    logic                     busy;
    logic [2:0]               countdown;
    logic [`CACHE_DATA_W-1:0] held_rdata;

    // untouched words read back a pattern built from every address bit
    function automatic logic [31:0] fill_word(input logic [29:0] wa);
        return {wa[13:0], wa[29:12]} ^ 32'h6b1d_35a9;
    endfunction

    assign req_ready = !busy && !stall;

    always @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            countdown <= '0;
            rsp_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            rsp_valid <= 1'b0;  // one pulse per accepted request
            if (req_valid && req_ready) begin
                busy      <= 1'b1;
                countdown <= 3'(latency) + 3'd1;
                if (req.we) begin
                    shadow[req.addr[31:2]] = req.wdata;
                    held_rdata             <= '0;
                end else begin
                    held_rdata <= shadow.exists(req.addr[31:2]) ?
                                  shadow[req.addr[31:2]] : fill_word(req.addr[31:2]);
                end
            end else if (busy) begin
                countdown <= countdown - 3'd1;
                if (countdown == 3'd1) begin
                    busy      <= 1'b0;
                    rsp_valid <= 1'b1;
                    rsp.rdata <= held_rdata;
                end
            end
        end
    end

endmodule

`default_nettype wire
